/* logic/proc_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the 16-bit five-stage pipeline
// opcodes, function codes, instruction formats and stage registers
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package proc_pkg;

    // default memory address widths, in words
    localparam int IMEM_DEPTH_LOG = 8;
    localparam int DMEM_DEPTH_LOG = 8;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ALU  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_BEQZ = 4'h5,
        OP_HALT = 4'h6
    } opcode_e;

    typedef enum logic [2:0] {
        FN_ADD = 3'd0,
        FN_SUB = 3'd1,
        FN_AND = 3'd2,
        FN_OR  = 3'd3,
        FN_XOR = 3'd4,
        FN_SLT = 3'd5
    } funct_e;

    ////////////////////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        funct_e   funct;
    } r_fmt_t;

    // for SW, rd names the data source
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic [5:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    localparam word_t NOP_WORD = {OP_NOP, 12'h000};

    ////////////////////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   valid;
        word_t  pc_plus;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc_plus;
        opcode_e  opcode;
        funct_e   funct;
        reg_idx_t rd;
        word_t    src_a;
        word_t    src_b;
        word_t    imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    alu_out;
        word_t    store_data;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

`default_nettype wire

/* logic/fetch.sv */
////////////////////////////////////////////////////////////////////////////
// fetch stage: pc, instruction memory with load port, fetch/decode register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter int IMEM_DEPTH_LOG = proc_pkg::IMEM_DEPTH_LOG
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  load_en,
    input  wire proc_pkg::word_t load_addr,
    input  wire proc_pkg::word_t load_data,
    input  wire                  stall,
    input  wire                  branch_taken,
    input  wire proc_pkg::word_t branch_target,
    input  wire                  halt_seen,
    output proc_pkg::if_id_t     if_id
);
    import proc_pkg::*;

    word_t imem [1 << IMEM_DEPTH_LOG];
    word_t pc;
    word_t fetched;

    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr[IMEM_DEPTH_LOG-1:0]] <= load_data;
        end
    end

    // same-cycle read
    assign fetched = imem[pc[IMEM_DEPTH_LOG-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (branch_taken) begin
            // redirect, and kill the word fetched this cycle
            pc            <= branch_target;
            if_id.valid   <= 1'b0;
            if_id.pc_plus <= branch_target;
            if_id.instr   <= NOP_WORD;
        end else if (stall) begin
            if_id <= if_id;
        end else if (halt_seen) begin
            if_id.valid <= 1'b0;
        end else begin
            pc            <= pc + 16'd1;
            if_id.valid   <= 1'b1;
            if_id.pc_plus <= pc + 16'd1;
            if_id.instr   <= fetched;
        end
    end

    a_pc_held: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !branch_taken |=> $stable(pc));

endmodule

`default_nettype wire

/* logic/decode.sv */
////////////////////////////////////////////////////////////////////////////
// decode stage: register file, control decode, hazard interlock,
// halt and illegal-opcode detection, decode/execute register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire proc_pkg::if_id_t  if_id,
    input  wire                    branch_taken,
    input  wire proc_pkg::id_ex_t  ex_dest,
    input  wire proc_pkg::ex_mem_t mem_dest,
    input  wire proc_pkg::retire_t retire,
    output proc_pkg::id_ex_t       id_ex,
    output logic                   stall,
    output logic                   halt_seen,
    output logic                   err
);
    import proc_pkg::*;

    word_t    rf [8];
    instr_u   ins;
    reg_idx_t src_a_idx, src_b_idx;
    word_t    src_a_val, src_b_val, imm_ext;
    logic     uses_a, uses_b, illegal;
    logic     reg_write, mem_read, mem_write;
    logic     halt_hit, halt_q;

    function automatic logic dest_match(reg_idx_t idx);
        return (ex_dest.valid && ex_dest.reg_write && ex_dest.rd == idx) ||
               (mem_dest.valid && mem_dest.reg_write && mem_dest.rd == idx);
    endfunction

    assign ins       = if_id.instr;
    assign src_a_idx = ins.r_fmt.rs;
    assign imm_ext   = {{10{ins.i_fmt.imm[5]}}, ins.i_fmt.imm};

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        uses_a    = 1'b0;
        uses_b    = 1'b0;
        illegal   = 1'b0;
        src_b_idx = ins.r_fmt.rt;
        case (ins.r_fmt.opcode)
            OP_ALU: begin
                reg_write = 1'b1;
                uses_a    = 1'b1;
                uses_b    = 1'b1;
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                uses_a    = 1'b1;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                uses_a    = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                uses_a    = 1'b1;
                uses_b    = 1'b1;
                src_b_idx = ins.i_fmt.rd;
            end
            OP_BEQZ: uses_a = 1'b1;
            OP_HALT, OP_NOP: ;
            default: illegal = 1'b1;
        endcase
        stall = if_id.valid && ((uses_a && dest_match(src_a_idx)) ||
                                (uses_b && dest_match(src_b_idx)));
    end

    // register file writes through to same-cycle reads
    always_ff @(posedge clk) begin
        if (retire.valid) begin
            rf[retire.rd] <= retire.data;
        end
    end

    assign src_a_val = (retire.valid && retire.rd == src_a_idx) ? retire.data : rf[src_a_idx];
    assign src_b_val = (retire.valid && retire.rd == src_b_idx) ? retire.data : rf[src_b_idx];

    // a halt behind a taken branch is on the wrong path
    assign halt_hit  = if_id.valid && ins.r_fmt.opcode == OP_HALT && !branch_taken;
    assign halt_seen = halt_q | halt_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_q <= 1'b0;
            err    <= 1'b0;
            id_ex  <= '0;
        end else begin
            halt_q          <= halt_seen;
            err             <= err | (if_id.valid && illegal && !branch_taken);
            id_ex.valid     <= if_id.valid && !stall && !branch_taken;
            id_ex.pc_plus   <= if_id.pc_plus;
            id_ex.opcode    <= ins.r_fmt.opcode;
            id_ex.funct     <= ins.r_fmt.funct;
            id_ex.rd        <= ins.r_fmt.rd;
            id_ex.src_a     <= src_a_val;
            id_ex.src_b     <= src_b_val;
            id_ex.imm       <= imm_ext;
            id_ex.reg_write <= reg_write;
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
        end
    end

    a_err_src: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(err) |-> $past(if_id.valid && ins.r_fmt.opcode > OP_HALT));

endmodule

`default_nettype wire

/* logic/execute.sv */
////////////////////////////////////////////////////////////////////////////
// execute stage: ALU, branch decision, execute/memory register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire proc_pkg::id_ex_t id_ex,
    output proc_pkg::ex_mem_t     ex_mem,
    output logic                  branch_taken,
    output proc_pkg::word_t       branch_target
);
    import proc_pkg::*;

    word_t opnd_b;
    word_t alu_res;

    // immediate forms use add, including load and store addresses
    always_comb begin
        opnd_b  = (id_ex.opcode == OP_ALU) ? id_ex.src_b : id_ex.imm;
        alu_res = id_ex.src_a + opnd_b;
        if (id_ex.opcode == OP_ALU) begin
            case (id_ex.funct)
                FN_SUB:  alu_res = id_ex.src_a - opnd_b;
                FN_AND:  alu_res = id_ex.src_a & opnd_b;
                FN_OR:   alu_res = id_ex.src_a | opnd_b;
                FN_XOR:  alu_res = id_ex.src_a ^ opnd_b;
                FN_SLT:  alu_res = {15'd0, $signed(id_ex.src_a) < $signed(opnd_b)};
                default: alu_res = id_ex.src_a + opnd_b;
            endcase
        end
    end

    assign branch_taken  = id_ex.valid && id_ex.opcode == OP_BEQZ && id_ex.src_a == '0;
    assign branch_target = id_ex.pc_plus + id_ex.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_out    <= alu_res;
            ex_mem.store_data <= id_ex.src_b;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

    // the slot behind a taken branch comes in as a bubble
    a_branch_flush: assert property (@(posedge clk) disable iff (!arst_n)
        branch_taken |=> !id_ex.valid);

endmodule

`default_nettype wire

/* logic/memory.sv */
////////////////////////////////////////////////////////////////////////////
// memory stage: data memory, write-back select and retire register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module memory #(
    parameter int DMEM_DEPTH_LOG = proc_pkg::DMEM_DEPTH_LOG
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire proc_pkg::ex_mem_t ex_mem,
    output proc_pkg::retire_t      retire
);
    import proc_pkg::*;

    word_t dmem [1 << DMEM_DEPTH_LOG];
    word_t rd_data;

    assign rd_data = dmem[ex_mem.alu_out[DMEM_DEPTH_LOG-1:0]];

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[ex_mem.alu_out[DMEM_DEPTH_LOG-1:0]] <= ex_mem.store_data;
        end
    end

    // stores never retire
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_mem.valid && ex_mem.reg_write;
            retire.rd    <= ex_mem.rd;
            retire.data  <= ex_mem.mem_read ? rd_data : ex_mem.alu_out;
        end
    end

endmodule

`default_nettype wire

/* logic/proc.sv */
////////////////////////////////////////////////////////////////////////////
// five-stage 16-bit processor top level
// fetch, decode, execute and memory with write-back folded in
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module proc #(
    parameter int IMEM_DEPTH_LOG = proc_pkg::IMEM_DEPTH_LOG,
    parameter int DMEM_DEPTH_LOG = proc_pkg::DMEM_DEPTH_LOG
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  load_en,
    input  wire proc_pkg::word_t load_addr,
    input  wire proc_pkg::word_t load_data,
    output proc_pkg::retire_t    retire,
    output logic                 halt,
    output logic                 err
);
    import proc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////////////////////////////////////////

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    logic    stall;
    logic    branch_taken;
    word_t   branch_target;

    fetch #(.IMEM_DEPTH_LOG(IMEM_DEPTH_LOG)) fetch0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (halt),
        .if_id         (if_id)
    );

    // decode sees execute and memory destinations for the interlock
    decode decode0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .if_id        (if_id),
        .branch_taken (branch_taken),
        .ex_dest      (id_ex),
        .mem_dest     (ex_mem),
        .retire       (retire),
        .id_ex        (id_ex),
        .stall        (stall),
        .halt_seen    (halt),
        .err          (err)
    );

    execute execute0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .id_ex         (id_ex),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory #(.DMEM_DEPTH_LOG(DMEM_DEPTH_LOG)) memory0 (
        .clk    (clk),
        .arst_n (arst_n),
        .ex_mem (ex_mem),
        .retire (retire)
    );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
////////////////////////////////////////////////////////////////////////////
// clock and reset source for the processor testbench
// reset lasts RST_CYCLES edges, and longer while hold is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 3
) (
    input  wire  hold,
    output logic clk,
    output logic arst_n
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            while (hold) @(posedge clk);
            #1 arst_n = 1'b1;
            // a new request resets at once
            @(posedge hold);
            arst_n = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verif/proc_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the five-stage processor
// loads programs during reset, checks every retirement, halt and err
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module proc_tb;
    import proc_pkg::*;

    localparam int unsigned SEED = 32'h67cbec91;
    localparam word_t HALT_WORD = {OP_HALT, 12'h000};
    // 4'hf is not an opcode
    localparam word_t ILLEGAL_WORD = 16'hF000;

    logic    clk;
    logic    arst_n;
    logic    hold;
    logic    load_en;
    word_t   load_addr;
    word_t   load_data;
    retire_t retire;
    logic    halt;
    logic    err;

    word_t    prog [$];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       phase_first [$];
    int       phase_exp_end [$];
    logic     phase_err [$];
    word_t    model_rf [8];
    word_t    model_dm [word_t];
    int       errors = 0;
    int       exp_idx = 0;
    logic     tables_built = 1'b0;

    clk_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) clk_gen0 (
        .hold   (hold),
        .clk    (clk),
        .arst_n (arst_n)
    );

    proc #(.IMEM_DEPTH_LOG(8), .DMEM_DEPTH_LOG(8)) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .retire    (retire),
        .halt      (halt),
        .err       (err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // encoders and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t sign_ext6(logic [5:0] v);
        return {{10{v[5]}}, v};
    endfunction

    function automatic word_t enc_r(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {OP_ALU, rd, rs, rt, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t alu_model(funct_e fn, word_t a, word_t b);
        case (fn)
            FN_SUB:  return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            FN_SLT:  return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: return a + b;
        endcase
    endfunction

    task automatic compare(string what, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic push_expect(reg_idx_t rd, word_t data);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic add_alu(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        prog.push_back(enc_r(fn, rd, rs, rt));
        model_rf[rd] = alu_model(fn, model_rf[rs], model_rf[rt]);
        push_expect(rd, model_rf[rd]);
    endtask

    task automatic add_addi(reg_idx_t rd, reg_idx_t rs, logic [5:0] imm);
        prog.push_back(enc_i(OP_ADDI, rd, rs, imm));
        model_rf[rd] = model_rf[rs] + sign_ext6(imm);
        push_expect(rd, model_rf[rd]);
    endtask

    // store data register sits in the rd field
    task automatic add_sw(reg_idx_t src, reg_idx_t base, logic [5:0] imm);
        prog.push_back(enc_i(OP_SW, src, base, imm));
        model_dm[model_rf[base] + sign_ext6(imm)] = model_rf[src];
    endtask

    task automatic add_lw(reg_idx_t rd, reg_idx_t base, logic [5:0] imm);
        prog.push_back(enc_i(OP_LW, rd, base, imm));
        model_rf[rd] = model_dm[model_rf[base] + sign_ext6(imm)];
        push_expect(rd, model_rf[rd]);
    endtask

    task automatic add_plain(word_t w);
        prog.push_back(w);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program and expectation tables
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_tables();
        logic [5:0] imm_a;
        logic [5:0] imm_b;
        logic [5:0] imm_c;
        logic [5:0] imm_d;
        foreach (model_rf[i]) model_rf[i] = '0;
        imm_a = 6'($urandom_range(31, 1));
        imm_b = 6'($urandom_range(63, 32));
        imm_c = 6'($urandom());
        imm_d = 6'($urandom());
        // alu ops, interlock, memory, branches and halt
        phase_first.push_back(prog.size());
        add_alu(FN_XOR, 3'd0, 3'd0, 3'd0);
        add_addi(3'd1, 3'd0, imm_a);
        add_addi(3'd2, 3'd0, imm_b);
        add_alu(FN_ADD, 3'd3, 3'd1, 3'd2);
        add_alu(FN_SUB, 3'd4, 3'd3, 3'd1);
        add_alu(FN_AND, 3'd5, 3'd4, 3'd2);
        add_alu(FN_OR, 3'd6, 3'd5, 3'd1);
        add_alu(FN_XOR, 3'd7, 3'd6, 3'd2);
        add_alu(FN_SLT, 3'd5, 3'd2, 3'd1);
        add_sw(3'd7, 3'd0, 6'd5);
        add_lw(3'd6, 3'd0, 6'd5);
        add_plain(enc_i(OP_BEQZ, 3'd0, 3'd0, 6'd2));
        add_plain(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd1));
        add_plain(enc_i(OP_ADDI, 3'd2, 3'd0, 6'd1));
        // r1 is never zero, so this one falls through
        add_plain(enc_i(OP_BEQZ, 3'd0, 3'd1, 6'd2));
        add_addi(3'd4, 3'd1, 6'd3);
        add_plain(HALT_WORD);
        add_plain(enc_i(OP_ADDI, 3'd3, 3'd0, 6'd9));
        phase_exp_end.push_back(exp_rd.size());
        phase_err.push_back(1'b0);
        // illegal opcode
        phase_first.push_back(prog.size());
        add_alu(FN_XOR, 3'd0, 3'd0, 3'd0);
        add_addi(3'd1, 3'd0, imm_c);
        add_plain(ILLEGAL_WORD);
        add_addi(3'd2, 3'd1, imm_d);
        add_plain(HALT_WORD);
        phase_exp_end.push_back(exp_rd.size());
        phase_err.push_back(1'b1);
    endtask

    task automatic load_program(int p);
        int last;
        int i;
        last = (p + 1 < phase_first.size()) ? phase_first[p + 1] : prog.size();
        for (i = phase_first[p]; i < last; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = 16'(i - phase_first[p]);
            load_data = prog[i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        hold    = 1'b0;
        @(posedge arst_n);
    endtask

    task automatic run_phase(int p);
        while (exp_idx < phase_exp_end[p]) @(negedge clk);
        while (!halt) @(negedge clk);
        // nothing may retire once halted
        repeat (8) begin
            @(negedge clk);
            compare("halt", 16'(halt), 16'd1);
            compare("err", 16'(err), 16'(phase_err[p]));
        end
        @(posedge clk);
        compare("retirement count", 16'(exp_idx), 16'(phase_exp_end[p]));
    endtask

    // retire monitor
    always @(negedge clk) begin
        if (arst_n && retire.valid) begin
            if (exp_idx >= exp_rd.size()) begin
                errors++;
                $display("ERROR @ %0t ns: r%0d retired with no retirement left to expect",
                         $time, retire.rd);
            end else begin
                compare("retire rd", 16'(retire.rd), 16'(exp_rd[exp_idx]));
                compare("retire data", retire.data, exp_data[exp_idx]);
            end
            exp_idx++;
        end
    end

    initial begin
        wait (tables_built);
        repeat (prog.size() * 12 + 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, the pipeline hung", prog.size() * 12 + 50);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int p;
        hold      = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(SEED));
        build_tables();
        tables_built = 1'b1;
        for (p = 0; p < phase_first.size(); p++) begin
            if (p > 0) begin
                @(posedge clk);
                #1 hold = 1'b1;
                @(negedge clk);
                compare("err in reset", 16'(err), 16'd0);
                compare("halt in reset", 16'(halt), 16'd0);
            end
            load_program(p);
            run_phase(p);
        end
        // sticky err clears only on reset
        @(posedge clk);
        #1 hold = 1'b1;
        @(negedge clk);
        compare("err after reset", 16'(err), 16'd0);
        $display("%0d errors, %0d of %0d retirements seen", errors, exp_idx, exp_rd.size());
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/proc_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
verif/clk_gen.sv
verif/proc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module proc_tb -f files.f -Mdir obj_dir -o proc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/proc_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
